/* design/cart_pkg.sv */
/*
 * Cart loader download definitions
 * Header mode and region settings, download word sizes and the
 * internal ROM header offsets used by the cartridge detector
 */
`default_nettype none

package cart_pkg;

	// ==========================================================
	// Settings
	// ==========================================================
	typedef enum logic [2:0] {
		AUTO,
		NO_HEADER,
		LOROM,
		HIROM,
		EXHIROM
	} header_mode_e;

	typedef enum logic [1:0] {
		REGION_AUTO,
		REGION_NTSC,
		REGION_PAL
	} region_mode_e;

	// ==========================================================
	// Download stream and header layout
	// ==========================================================
	localparam int DL_WORD_W = 16;
	localparam int MASK_W    = 24;
	localparam int CODE_W    = 128; // Flags, address, compare, replace

	localparam logic [7:0] CHEAT_INDEX = 8'hFF; // Any other index is a cartridge

	// ROM size word of the internal header, RAM size is 2 bytes above
	localparam logic [23:0] LOROM_SIZE_ADDR   = 24'h007FD6;
	localparam logic [23:0] HIROM_SIZE_ADDR   = 24'h00FFD6;
	localparam logic [23:0] EXHIROM_SIZE_ADDR = 24'h40FFD6;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

endpackage

`default_nettype wire

/* design/save_pkg.sv */
/*
 * Backup RAM definitions
 * Sequencer states and SD sector geometry
 */
`default_nettype none

package save_pkg;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_e;

	// 512 byte sectors
	localparam int SECTOR_SHIFT = 9;
	localparam int LBA_W        = 32;

endpackage

`default_nettype wire

/* design/rom_header_detect.sv */
/*
 * ROM header detector
 * Picks ROM type, ROM and RAM size masks and video region out of the
 * cartridge download, from the copier header or the internal header
 */
`timescale 1ns/100ps
`default_nettype none

module rom_header_detect #(
	parameter int COPIER_HDR_BYTES = 512,
	parameter int ADDR_W           = 25
) (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire                           ioctl_download_i,
	input  wire [7:0]                     ioctl_index_i,
	input  wire                           ioctl_wr_i,
	input  wire [ADDR_W-1:0]              ioctl_addr_i,
	input  wire [cart_pkg::DL_WORD_W-1:0] ioctl_dout_i,
	input  wire cart_pkg::header_mode_e   header_mode_i,
	input  wire cart_pkg::region_mode_e   region_mode_i,
	output wire                           cart_active_o,
	output logic [7:0]                    rom_type_o,
	output logic [cart_pkg::MASK_W-1:0]   rom_mask_o,
	output logic [cart_pkg::MASK_W-1:0]   ram_mask_o,
	output logic                          pal_o
);

	localparam int MW = cart_pkg::MASK_W;
	localparam logic [MW-1:0] ONE_KB = MW'(1024);

	// Internal header lands behind the copier header
	localparam logic [ADDR_W-1:0] HDR_OFS = ADDR_W'(COPIER_HDR_BYTES);
	localparam logic [ADDR_W-1:0] LO_ADDR = ADDR_W'(cart_pkg::LOROM_SIZE_ADDR) + HDR_OFS;
	localparam logic [ADDR_W-1:0] HI_ADDR = ADDR_W'(cart_pkg::HIROM_SIZE_ADDR) + HDR_OFS;
	localparam logic [ADDR_W-1:0] EX_ADDR = ADDR_W'(cart_pkg::EXHIROM_SIZE_ADDR) + HDR_OFS;

	logic [3:0]        rom_size;
	logic [3:0]        ram_size;
	logic [3:0]        rom_size_nxt;
	logic [3:0]        ram_size_nxt;
	logic              rom_region;
	logic [ADDR_W-1:0] size_addr;
	logic              hdr_fixed;  // Mode forces an internal header

	wire cart_wr = cart_active_o & ioctl_wr_i;

	assign cart_active_o = ioctl_download_i & (ioctl_index_i != cart_pkg::CHEAT_INDEX);

	// 1 KB shifted by the size code
	function automatic logic [MW-1:0] size_mask(input logic [3:0] size);
		return (ONE_KB << size) - MW'(1);
	endfunction

	always_comb begin
		hdr_fixed = 1'b1;
		case (header_mode_i)
			cart_pkg::LOROM:   size_addr = LO_ADDR;
			cart_pkg::HIROM:   size_addr = HI_ADDR;
			cart_pkg::EXHIROM: size_addr = EX_ADDR;
			default: begin
				size_addr = '0;
				hdr_fixed = 1'b0;
			end
		endcase
	end

	// Size codes after this word, masks are built from these
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (ioctl_addr_i == '0) begin
			rom_size_nxt = cart_pkg::DEFAULT_ROM_SIZE;
			ram_size_nxt = 4'h0;
			if (header_mode_i == cart_pkg::AUTO && ioctl_dout_i[7:0] != 8'h00)
				{ram_size_nxt, rom_size_nxt} = ioctl_dout_i[7:0]; // Copier header sizes
		end
		if (hdr_fixed && ioctl_addr_i == size_addr)
			rom_size_nxt = ioctl_dout_i[11:8];
		if (hdr_fixed && ioctl_addr_i == size_addr + ADDR_W'(2))
			ram_size_nxt = ioctl_dout_i[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_region <= 1'b0;
			rom_type_o <= 8'h00;
			rom_mask_o <= '0;
			ram_mask_o <= '0;
			pal_o      <= 1'b0;
		end else begin
			if (cart_wr) begin
				rom_size   <= rom_size_nxt;
				ram_size   <= ram_size_nxt;
				rom_mask_o <= size_mask(rom_size_nxt);
				ram_mask_o <= (ram_size_nxt != 4'h0) ? size_mask(ram_size_nxt) : '0;
				if (ioctl_addr_i == '0) begin
					case (header_mode_i)
						cart_pkg::AUTO:    rom_type_o <= ioctl_dout_i[15:8];
						cart_pkg::HIROM:   rom_type_o <= 8'd1;
						cart_pkg::EXHIROM: rom_type_o <= 8'd2;
						default:           rom_type_o <= 8'd0; // No header, LoROM
					endcase
				end
				if (ioctl_addr_i == ADDR_W'(2))
					rom_region <= ioctl_dout_i[8];
			end

			// Region only moves between downloads
			if (!cart_active_o) begin
				case (region_mode_i)
					cart_pkg::REGION_NTSC: pal_o <= 1'b0;
					cart_pkg::REGION_PAL:  pal_o <= 1'b1;
					default:               pal_o <= rom_region;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/cheat_code_assembler.sv */
/*
 * Cheat code assembler
 * Packs eight download words of a cheat record into one code
 * and strobes it out once the last word arrives
 */
`timescale 1ns/100ps
`default_nettype none

module cheat_code_assembler #(
	parameter int ADDR_W = 25
) (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire                           ioctl_download_i,
	input  wire [7:0]                     ioctl_index_i,
	input  wire                           ioctl_wr_i,
	input  wire [ADDR_W-1:0]              ioctl_addr_i,
	input  wire [cart_pkg::DL_WORD_W-1:0] ioctl_dout_i,
	output logic [cart_pkg::CODE_W-1:0]   code_o,
	output logic                          code_valid_o
);

	wire code_wr = ioctl_download_i & ioctl_wr_i & (ioctl_index_i == cart_pkg::CHEAT_INDEX);

	// Layout is flags 127:96, address 95:64, compare 63:32, replace 31:0
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr_i[3:0])
				4'd0:  code_o[111:96]  <= ioctl_dout_i; // Flags low
				4'd2:  code_o[127:112] <= ioctl_dout_i;
				4'd4:  code_o[79:64]   <= ioctl_dout_i; // Address low
				4'd6:  code_o[95:80]   <= ioctl_dout_i;
				4'd8:  code_o[47:32]   <= ioctl_dout_i; // Compare low
				4'd10: code_o[63:48]   <= ioctl_dout_i;
				4'd12: code_o[15:0]    <= ioctl_dout_i; // Replace low
				4'd14: code_o[31:16]   <= ioctl_dout_i;
				default: ;
			endcase
		end
	end

	// Last word of the record completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid_o <= 1'b0;
		else
			code_valid_o <= code_wr && (ioctl_addr_i[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

/* design/backup_sequencer.sv */
/*
 * Backup RAM sequencer
 * Moves the cartridge RAM to and from the SD image one sector at a
 * time and keeps the enable and unsaved write flags
 */
`timescale 1ns/100ps
`default_nettype none

module backup_sequencer #(
	parameter int ADDR_W = 25
) (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          cart_active_i,
	input  wire [cart_pkg::MASK_W-1:0]   ram_mask_i,
	input  wire                          img_mounted_i,
	input  wire                          img_readonly_i,
	input  wire [63:0]                   img_size_i,
	input  wire                          bk_load_i,
	input  wire                          bk_save_i,
	input  wire                          autosave_i,
	input  wire                          osd_status_i,
	input  wire                          bsram_write_i,
	input  wire                          sd_ack_i,
	output logic [save_pkg::LBA_W-1:0]   sd_lba_o,
	output logic                         sd_rd_o,
	output logic                         sd_wr_o,
	output wire                          busy_o,
	output logic                         loading_o,
	output logic                         pending_o
);

	localparam int SECT_W = ADDR_W - save_pkg::SECTOR_SHIFT;

	save_pkg::bk_state_e state;
	logic                bk_ena;
	logic                old_cart;
	logic                old_load;
	logic                old_save;
	logic                old_ack;
	logic [SECT_W-1:0]   last_sector;

	wire load_req  = bk_load_i & bk_ena;
	wire save_req  = (bk_save_i | (pending_o & osd_status_i & autosave_i)) & bk_ena;
	wire cart_done = old_cart & ~cart_active_i;
	wire ack_rise  = sd_ack_i & ~old_ack;
	wire ack_fall  = old_ack & ~sd_ack_i;

	assign last_sector = SECT_W'(ram_mask_i >> save_pkg::SECTOR_SHIFT);
	assign busy_o      = (state == save_pkg::BK_XFER);

	// ==========================================================
	// Enable and pending flags
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_cart  <= 1'b0;
			bk_ena    <= 1'b0;
			pending_o <= 1'b0;
		end else begin
			old_cart <= cart_active_i;
			if (!old_cart && cart_active_i)
				bk_ena <= 1'b0; // New cartridge
			if (cart_active_i && img_mounted_i && !img_readonly_i)
				bk_ena <= (ram_mask_i != '0); // Image is mounted before download ends

			if (bk_ena && !osd_status_i && bsram_write_i)
				pending_o <= 1'b1;
			else if (busy_o)
				pending_o <= 1'b0;
		end
	end

	// ==========================================================
	// Sector transfer FSM
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= save_pkg::BK_IDLE;
			old_load  <= 1'b0;
			old_save  <= 1'b0;
			old_ack   <= 1'b0;
			loading_o <= 1'b0;
			sd_lba_o  <= '0;
			sd_rd_o   <= 1'b0;
			sd_wr_o   <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_ack  <= sd_ack_i;

			// Host took the request
			if (ack_rise) begin
				sd_rd_o <= 1'b0;
				sd_wr_o <= 1'b0;
			end

			if (state == save_pkg::BK_IDLE) begin
				if ((load_req && !old_load) || (save_req && !old_save)) begin
					state     <= save_pkg::BK_XFER;
					loading_o <= load_req; // Load wins over save
					sd_lba_o  <= '0;
					sd_rd_o   <= load_req;
					sd_wr_o   <= ~load_req;
				end
				// Restore saved RAM right after the cartridge
				if (cart_done && img_size_i != '0 && bk_ena) begin
					state     <= save_pkg::BK_XFER;
					loading_o <= 1'b1;
					sd_lba_o  <= '0;
					sd_rd_o   <= 1'b1;
					sd_wr_o   <= 1'b0;
				end
			end else if (ack_fall) begin
				if (sd_lba_o >= save_pkg::LBA_W'(last_sector)) begin
					state     <= save_pkg::BK_IDLE;
					loading_o <= 1'b0;
				end else begin
					sd_lba_o <= sd_lba_o + save_pkg::LBA_W'(1);
					sd_rd_o  <= loading_o;
					sd_wr_o  <= ~loading_o;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/cart_loader_top.sv */
/*
 * Cart loader top level
 * Header detection, cheat code assembly and backup RAM sequencing
 * on the shared download stream
 */
`timescale 1ns/100ps
`default_nettype none

module cart_loader_top #(
	parameter int ADDR_W           = 25,
	parameter int COPIER_HDR_BYTES = 512
) (
	input  wire                           clk_sys,
	input  wire                           RESET,
	// Download stream
	input  wire                           ioctl_download_i,
	input  wire [7:0]                     ioctl_index_i,
	input  wire                           ioctl_wr_i,
	input  wire [ADDR_W-1:0]              ioctl_addr_i,
	input  wire [cart_pkg::DL_WORD_W-1:0] ioctl_dout_i,
	// Settings
	input  wire cart_pkg::header_mode_e   header_mode_i,
	input  wire cart_pkg::region_mode_e   region_mode_i,
	input  wire                           bk_load_i,
	input  wire                           bk_save_i,
	input  wire                           autosave_i,
	input  wire                           osd_status_i,
	// Image and BSRAM activity
	input  wire                           img_mounted_i,
	input  wire                           img_readonly_i,
	input  wire [63:0]                    img_size_i,
	input  wire                           bsram_write_i,
	input  wire                           sd_ack_i,
	output wire                           cart_active_o,
	output wire [7:0]                     rom_type_o,
	output wire [cart_pkg::MASK_W-1:0]    rom_mask_o,
	output wire [cart_pkg::MASK_W-1:0]    ram_mask_o,
	output wire                           pal_o,
	output wire [cart_pkg::CODE_W-1:0]    code_o,
	output wire                           code_valid_o,
	output wire [save_pkg::LBA_W-1:0]     sd_lba_o,
	output wire                           sd_rd_o,
	output wire                           sd_wr_o,
	output wire                           busy_o,
	output wire                           loading_o,
	output wire                           pending_o
);

	wire                        cart_active;
	wire [cart_pkg::MASK_W-1:0] ram_mask;

	assign cart_active_o = cart_active;
	assign ram_mask_o    = ram_mask;

	rom_header_detect #(
		.COPIER_HDR_BYTES (COPIER_HDR_BYTES),
		.ADDR_W           (ADDR_W)
	) hdr0 (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.header_mode_i    (header_mode_i),
		.region_mode_i    (region_mode_i),
		.cart_active_o    (cart_active),
		.rom_type_o       (rom_type_o),
		.rom_mask_o       (rom_mask_o),
		.ram_mask_o       (ram_mask),
		.pal_o            (pal_o)
	);

	cheat_code_assembler #(
		.ADDR_W (ADDR_W)
	) cheat0 (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.code_o           (code_o),
		.code_valid_o     (code_valid_o)
	);

	backup_sequencer #(
		.ADDR_W (ADDR_W)
	) bk0 (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cart_active_i  (cart_active),
		.ram_mask_i     (ram_mask),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.bk_load_i      (bk_load_i),
		.bk_save_i      (bk_save_i),
		.autosave_i     (autosave_i),
		.osd_status_i   (osd_status_i),
		.bsram_write_i  (bsram_write_i),
		.sd_ack_i       (sd_ack_i),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.busy_o         (busy_o),
		.loading_o      (loading_o),
		.pending_o      (pending_o)
	);

endmodule

`default_nettype wire

/* test/cart_loader_assertions.sv */
/*
 * Backup sequencer SD strobe checks
 * Bound into every backup sequencer instance
 */
`timescale 1ns/100ps
`default_nettype none

module cart_loader_assertions (
	input wire                       clk_sys,
	input wire                       RESET,
	input wire                       sd_rd_i,
	input wire                       sd_wr_i,
	input wire                       sd_ack_i,
	input wire                       busy_i,
	input wire [save_pkg::LBA_W-1:0] sd_lba_i
);

	// Read and write are never requested together
	strobe_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd_i && sd_wr_i))
		else $error("SD read and write strobes high together");

	strobe_idle: assert property (@(posedge clk_sys) disable iff (RESET)
		!busy_i |-> !(sd_rd_i || sd_wr_i))
		else $error("SD strobe high while the sequencer is idle");

	// Sector address held until the host answers
	lba_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd_rd_i || sd_wr_i) && !sd_ack_i |=> $stable(sd_lba_i))
		else $error("SD sector address moved while waiting for acknowledge");

endmodule

bind backup_sequencer cart_loader_assertions asrt0 (
	.clk_sys  (clk_sys),
	.RESET    (RESET),
	.sd_rd_i  (sd_rd_o),
	.sd_wr_i  (sd_wr_o),
	.sd_ack_i (sd_ack_i),
	.busy_i   (busy_o),
	.sd_lba_i (sd_lba_o)
);

`default_nettype wire

/* test/tb_cart_loader.sv */
/*
 * Cart loader testbench
 * Table driven header checks, cheat code assembly and backup RAM
 * transfers against an SD responder with random acknowledge delay
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cart_loader;

	localparam int ADDR_W        = 25;
	localparam int NUM_ROWS      = 6;
	localparam int MAX_SECTORS   = 16;  // Largest RAM in the table
	localparam int ACK_WORST     = 8;
	localparam int SECTOR_CYCLES = ACK_WORST + 6;
	localparam int TEST_CYCLES   = 60;  // Download and checks of one test
	localparam int WATCHDOG_CYCLES =
		2 * (NUM_ROWS + 3) * (MAX_SECTORS * SECTOR_CYCLES + TEST_CYCLES);
	localparam logic [ADDR_W-1:0] CHEAT_BASE = 25'h0000020;

	typedef struct packed {
		cart_pkg::header_mode_e hmode;
		cart_pkg::region_mode_e rmode;
		logic [15:0]            w0;
		logic [15:0]            w2;
		logic [ADDR_W-1:0]      hdr_addr;  // Internal header ROM size word
		logic [15:0]            hdr_rom;
		logic [15:0]            hdr_ram;
		logic [7:0]             exp_type;
		logic [23:0]            exp_rom_mask;
		logic [23:0]            exp_ram_mask;
		logic                   exp_pal;
	} hdr_row_t;

	logic                   clk_sys;
	logic                   RESET;
	logic                   ioctl_download_i;
	logic [7:0]             ioctl_index_i;
	logic                   ioctl_wr_i;
	logic [ADDR_W-1:0]      ioctl_addr_i;
	logic [15:0]            ioctl_dout_i;
	cart_pkg::header_mode_e header_mode_i;
	cart_pkg::region_mode_e region_mode_i;
	logic                   bk_load_i;
	logic                   bk_save_i;
	logic                   autosave_i;
	logic                   osd_status_i;
	logic                   img_mounted_i;
	logic                   img_readonly_i;
	logic [63:0]            img_size_i;
	logic                   bsram_write_i;
	logic                   sd_ack_i;
	wire                    cart_active_o;
	wire  [7:0]             rom_type_o;
	wire  [23:0]            rom_mask_o;
	wire  [23:0]            ram_mask_o;
	wire                    pal_o;
	wire  [127:0]           code_o;
	wire                    code_valid_o;
	wire  [31:0]            sd_lba_o;
	wire                    sd_rd_o;
	wire                    sd_wr_o;
	wire                    busy_o;
	wire                    loading_o;
	wire                    pending_o;

	hdr_row_t    table_rows [NUM_ROWS];
	logic [15:0] cheat_words [8];
	logic [15:0] lfsr_state;
	int          value_errors = 0;
	int          other_errors = 0;
	int          rd_count     = 0;  // Sectors seen at the responder
	int          wr_count     = 0;
	int          valid_count  = 0;

	cart_loader_top #(
		.ADDR_W           (ADDR_W),
		.COPIER_HDR_BYTES (512)
	) dut0 (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.header_mode_i    (header_mode_i),
		.region_mode_i    (region_mode_i),
		.bk_load_i        (bk_load_i),
		.bk_save_i        (bk_save_i),
		.autosave_i       (autosave_i),
		.osd_status_i     (osd_status_i),
		.img_mounted_i    (img_mounted_i),
		.img_readonly_i   (img_readonly_i),
		.img_size_i       (img_size_i),
		.bsram_write_i    (bsram_write_i),
		.sd_ack_i         (sd_ack_i),
		.cart_active_o    (cart_active_o),
		.rom_type_o       (rom_type_o),
		.rom_mask_o       (rom_mask_o),
		.ram_mask_o       (ram_mask_o),
		.pal_o            (pal_o),
		.code_o           (code_o),
		.code_valid_o     (code_valid_o),
		.sd_lba_o         (sd_lba_o),
		.sd_rd_o          (sd_rd_o),
		.sd_wr_o          (sd_wr_o),
		.busy_o           (busy_o),
		.loading_o        (loading_o),
		.pending_o        (pending_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Random acknowledge delay
	// ============================================================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int take_random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("Fail %s: got %0h, expected %0h", name, got, exp);
		value_errors++;
	endtask

	// SD host model, one sector per strobe
	initial begin : ack_responder
		int                         delay;
		logic [save_pkg::LBA_W-1:0] next_lba;
		lfsr_state = 16'd91;
		next_lba   = '0;
		sd_ack_i  <= 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!busy_o)
				next_lba = '0;  // Every transfer starts at sector 0
			if (sd_rd_o || sd_wr_o) begin
				if (sd_lba_o !== next_lba)
					report_mismatch("sd_lba_o", sd_lba_o, next_lba);
				next_lba = next_lba + 1'b1;
				if (sd_rd_o)
					rd_count++;
				else
					wr_count++;
				delay = 1 + take_random_bits(3);
				repeat (delay) @(posedge clk_sys);
				sd_ack_i <= 1'b1;
				@(negedge clk_sys);
				while (sd_rd_o || sd_wr_o)
					@(negedge clk_sys);
				@(posedge clk_sys);
				sd_ack_i <= 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (code_valid_o)
			valid_count++;
	end

	// ============================================================
	// Stimulus and checks
	// ============================================================
	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
		ioctl_addr_i <= addr;
		ioctl_dout_i <= data;
		ioctl_wr_i   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic run_cart_row(input int r);
		hdr_row_t row;
		row = table_rows[r];
		@(posedge clk_sys);
		header_mode_i    <= row.hmode;
		region_mode_i    <= row.rmode;
		ioctl_index_i    <= 8'h00;
		ioctl_download_i <= 1'b1;
		@(posedge clk_sys);
		write_word(25'h0000000, row.w0);
		write_word(25'h0000002, row.w2);
		write_word(25'h000000E, row.w2);  // Last slot of a cheat record
		write_word(row.hdr_addr, row.hdr_rom);
		write_word(row.hdr_addr + 25'd2, row.hdr_ram);
		@(negedge clk_sys);
		if (cart_active_o !== 1'b1)
			report_mismatch("cart_active_o", cart_active_o, 1'b1);
		repeat (3) @(posedge clk_sys);
		ioctl_download_i <= 1'b0;
	endtask

	task automatic expect_idle(input int cycles);
		bit seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge clk_sys);
			if (busy_o)
				seen = 1'b1;
		end
		if (seen) begin
			$display("Backup transfer started with no backup RAM enabled");
			other_errors++;
		end
	endtask

	task automatic watch_transfer(input logic expect_load, input int sectors,
		input int rd_base, input int wr_base);
		int start_wait;
		start_wait = 0;
		while (!busy_o && start_wait < 8) begin
			@(negedge clk_sys);
			start_wait++;
		end
		if (!busy_o) begin
			$display("Backup transfer did not start");
			other_errors++;
		end else begin
			while (busy_o) begin
				if (loading_o !== expect_load)
					report_mismatch("loading_o", loading_o, expect_load);
				@(negedge clk_sys);
			end
			if (loading_o !== 1'b0)
				report_mismatch("loading_o", loading_o, 1'b0);
			if (rd_count - rd_base != (expect_load ? sectors : 0))
				report_mismatch("sd_rd_o sectors", rd_count - rd_base,
					expect_load ? sectors : 0);
			if (wr_count - wr_base != (expect_load ? 0 : sectors))
				report_mismatch("sd_wr_o sectors", wr_count - wr_base,
					expect_load ? 0 : sectors);
		end
	endtask

	task automatic finish_cart_row(input int r);
		hdr_row_t row;
		int       rd_base;
		int       wr_base;
		row     = table_rows[r];
		rd_base = rd_count;
		wr_base = wr_count;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		if (cart_active_o !== 1'b0)
			report_mismatch("cart_active_o", cart_active_o, 1'b0);
		if (rom_type_o !== row.exp_type)
			report_mismatch("rom_type_o", rom_type_o, row.exp_type);
		if (rom_mask_o !== row.exp_rom_mask)
			report_mismatch("rom_mask_o", rom_mask_o, row.exp_rom_mask);
		if (ram_mask_o !== row.exp_ram_mask)
			report_mismatch("ram_mask_o", ram_mask_o, row.exp_ram_mask);
		if (pal_o !== row.exp_pal)
			report_mismatch("pal_o", pal_o, row.exp_pal);
		if (row.exp_ram_mask != '0)
			watch_transfer(1'b1, int'(row.exp_ram_mask >> save_pkg::SECTOR_SHIFT) + 1,
				rd_base, wr_base);
		else
			expect_idle(12);
	endtask

	task automatic check_autosave();
		int sectors;
		int rd_base;
		int wr_base;
		sectors = int'(table_rows[NUM_ROWS-1].exp_ram_mask >> save_pkg::SECTOR_SHIFT) + 1;
		@(negedge clk_sys);
		if (pending_o !== 1'b0)
			report_mismatch("pending_o", pending_o, 1'b0);
		@(posedge clk_sys);
		bsram_write_i <= 1'b1;  // OSD still closed
		@(posedge clk_sys);
		bsram_write_i <= 1'b0;
		@(negedge clk_sys);
		if (pending_o !== 1'b1)
			report_mismatch("pending_o", pending_o, 1'b1);
		rd_base = rd_count;
		wr_base = wr_count;
		@(posedge clk_sys);
		autosave_i   <= 1'b1;
		osd_status_i <= 1'b1;
		watch_transfer(1'b0, sectors, rd_base, wr_base);
		if (pending_o !== 1'b0)
			report_mismatch("pending_o", pending_o, 1'b0);
		@(posedge clk_sys);
		autosave_i   <= 1'b0;
		osd_status_i <= 1'b0;
	endtask

	task automatic check_no_ram();
		run_cart_row(1);
		finish_cart_row(1);
		@(posedge clk_sys);
		bk_load_i     <= 1'b1;
		@(posedge clk_sys);
		bk_load_i     <= 1'b0;
		bk_save_i     <= 1'b1;
		@(posedge clk_sys);
		bk_save_i     <= 1'b0;
		bsram_write_i <= 1'b1;
		@(posedge clk_sys);
		bsram_write_i <= 1'b0;
		osd_status_i  <= 1'b1;
		autosave_i    <= 1'b1;
		expect_idle(12);
		if (pending_o !== 1'b0)
			report_mismatch("pending_o", pending_o, 1'b0);
		@(posedge clk_sys);
		osd_status_i  <= 1'b0;
		autosave_i    <= 1'b0;
	endtask

	task automatic check_cheat_code();
		logic [127:0] expected;
		int           base;
		// Flags, address, compare, replace with the high word first
		expected = {cheat_words[1], cheat_words[0], cheat_words[3], cheat_words[2],
			cheat_words[5], cheat_words[4], cheat_words[7], cheat_words[6]};
		base = valid_count;
		@(posedge clk_sys);
		ioctl_index_i    <= cart_pkg::CHEAT_INDEX;
		ioctl_download_i <= 1'b1;
		@(posedge clk_sys);
		for (int k = 0; k < 8; k++)
			write_word(CHEAT_BASE + ADDR_W'(2 * k), cheat_words[k]);
		@(negedge clk_sys);
		if (cart_active_o !== 1'b0)
			report_mismatch("cart_active_o", cart_active_o, 1'b0);  // Cheat file
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		if (valid_count - base != 1)
			report_mismatch("code_valid_o pulses", valid_count - base, 1);
		if (code_o !== expected)
			report_mismatch("code_o", code_o, expected);
	endtask

	initial begin : main_sequence
		// Modes, word 0, word 2, header address and words, then expected
		// type, ROM mask, RAM mask and PAL
		table_rows[0] = '{cart_pkg::AUTO, cart_pkg::REGION_AUTO, 16'h2521, 16'h0100,
			25'h00081D6, 16'h0F00, 16'h000F, 8'h25, 24'h0007FF, 24'h000FFF, 1'b1};
		table_rows[1] = '{cart_pkg::AUTO, cart_pkg::REGION_NTSC, 16'h1300, 16'h0100,
			25'h00081D6, 16'h0F00, 16'h000F, 8'h13, 24'h3FFFFF, 24'h000000, 1'b0};
		table_rows[2] = '{cart_pkg::NO_HEADER, cart_pkg::REGION_PAL, 16'h4433, 16'h0000,
			25'h00081D6, 16'h0F00, 16'h000F, 8'h00, 24'h3FFFFF, 24'h000000, 1'b1};
		table_rows[3] = '{cart_pkg::LOROM, cart_pkg::REGION_AUTO, 16'h0021, 16'h00FF,
			25'h00081D6, 16'hFA00, 16'h00F1, 8'h00, 24'h0FFFFF, 24'h0007FF, 1'b0};
		table_rows[4] = '{cart_pkg::HIROM, cart_pkg::REGION_AUTO, 16'h0000, 16'h0100,
			25'h00101D6, 16'h0B00, 16'h0003, 8'h01, 24'h1FFFFF, 24'h001FFF, 1'b1};
		table_rows[5] = '{cart_pkg::EXHIROM, cart_pkg::REGION_NTSC, 16'h5A21, 16'h0100,
			25'h04101D6, 16'h0C00, 16'h0002, 8'h02, 24'h3FFFFF, 24'h000FFF, 1'b0};
		cheat_words = '{16'h0012, 16'h3400, 16'h5678, 16'h009A,
			16'hBEEF, 16'hCAFE, 16'h00C3, 16'h7E5A};

		RESET            <= 1'b1;
		ioctl_download_i <= 1'b0;
		ioctl_index_i    <= 8'h00;
		ioctl_wr_i       <= 1'b0;
		ioctl_addr_i     <= '0;
		ioctl_dout_i     <= 16'h0000;
		header_mode_i    <= cart_pkg::AUTO;
		region_mode_i    <= cart_pkg::REGION_AUTO;
		bk_load_i        <= 1'b0;
		bk_save_i        <= 1'b0;
		autosave_i       <= 1'b0;
		osd_status_i     <= 1'b0;
		img_mounted_i    <= 1'b1;   // Writable save image present
		img_readonly_i   <= 1'b0;
		img_size_i       <= 64'h2000;
		bsram_write_i    <= 1'b0;
		repeat (3) @(posedge clk_sys);
		RESET <= 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_cart_row(r);
			finish_cart_row(r);
		end
		if (valid_count != 0)
			report_mismatch("code_valid_o pulses", valid_count, 0);

		check_autosave();
		check_no_ram();
		check_cheat_code();

		$display("Errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
design/cart_pkg.sv
design/save_pkg.sv
design/rom_header_detect.sv
design/cheat_code_assembler.sv
design/backup_sequencer.sv
design/cart_loader_top.sv
test/cart_loader_assertions.sv
test/tb_cart_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the cart loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_cart_loader
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f \
	--top-module tb_cart_loader \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG_FILE"; then
	echo "Testbench reported a failure"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
